//--- rtl/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////
	// fetch front end sizes

	localparam int inst_width       = 32;
	localparam int addr_width       = 6;
	localparam int mem_depth        = 64;	// words, one per address
	localparam int halt_opcode_bits = 6;	// top bits, all ones = halt

	typedef logic [inst_width-1:0] inst_t;

	// program download port into the instruction memory
	typedef struct packed {
		logic                  en;
		logic [addr_width-1:0] addr;
		inst_t                 data;
	} mem_write_t;

	// what the fetch unit shows to the debug unit and the host side
	typedef struct packed {
		logic [addr_width-1:0] pc;
		inst_t                 instr;	// word at pc
		logic                  halted;
	} fetch_status_t;

	function automatic logic is_halt(input inst_t instr);
		return &instr[inst_width-1 -: halt_opcode_bits];
	endfunction

endpackage

//--- rtl/debug_pkg.sv
package debug_pkg;

	typedef logic [7:0] byte_t;

	//////////////////////////////////////////////////
	// host command bytes

	localparam byte_t cmd_start      = 8'h01;
	localparam byte_t cmd_continuous = 8'h02;
	localparam byte_t cmd_step_mode  = 8'h03;
	localparam byte_t cmd_reprogram  = 8'h05;
	localparam byte_t cmd_step       = 8'h06;

	//////////////////////////////////////////////////
	// debug FSM

	typedef enum logic [2:0] {
		idle        = 3'd0,
		programming = 3'd1,	// downloading words
		waiting     = 3'd2,	// program loaded, wait for run mode
		step_mode   = 3'd3,
		running     = 3'd4,
		sending     = 3'd5	// report to host
	} debug_state_t;

	// report is pc byte then status byte
	localparam int report_bytes = 2;

endpackage

//--- rtl/inst_mem.sv
module inst_mem
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  mem_write_t            mem_write,
	input  logic [addr_width-1:0] rd_addr,
	output inst_t                 rd_data
);

	inst_t mem [mem_depth];

	// written only during program download
	always_ff @(posedge clk)
	begin
		if (mem_write.en)
			mem[mem_write.addr] <= mem_write.data;
	end

	assign rd_data = mem[rd_addr];	// async read, same cycle as pc

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fetch_clear,
	input  logic                  cpu_run,
	input  logic                  cpu_step,
	input  inst_t                 rd_data,
	output logic [addr_width-1:0] rd_addr,
	output fetch_status_t         status
);

	logic [addr_width-1:0] pc;
	logic                  halted;
	logic                  advance;

	assign advance = (cpu_run | cpu_step) & ~halted;

	// one instruction per cycle while enabled
	always_ff @(posedge clk)
	begin
		if (reset || fetch_clear)
		begin
			pc     <= '0;
			halted <= 1'b0;
		end
		else if (advance)
		begin
			if (is_halt(rd_data))
				halted <= 1'b1;	// pc stays on the halt word
			else
				pc <= pc + 1'b1;	// wraps at 64
		end
	end

	assign rd_addr = pc;

	assign status = '{pc: pc, instr: rd_data, halted: halted};

endmodule

//--- rtl/debug_unit.sv
module debug_unit
	import cpu_pkg::*, debug_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          rx_done_tick,
	input  byte_t         rx_data,
	input  logic          tx_done_tick,
	output logic          tx_start,
	output byte_t         tx_data,
	input  fetch_status_t status,
	output mem_write_t    mem_write,
	output logic          fetch_clear,
	output logic          cpu_run,
	output logic          cpu_step,
	output logic          debug_active
);

	debug_state_t state;

	logic rx_tick_q;
	logic tx_tick_q;
	logic rx_edge;
	logic tx_edge;

	logic [1:0]            byte_cnt;	// next byte slot of the word
	logic                  wr_en;
	logic [addr_width-1:0] wr_addr;
	inst_t                 word;

	logic [$clog2(report_bytes)-1:0] tx_idx;
	logic                            tx_busy;	// waiting for tx_done_tick
	logic                            from_step;	// return to step_mode after report
	byte_t                           report_byte;

	assign rx_edge = rx_done_tick & ~rx_tick_q;
	assign tx_edge = tx_done_tick & ~tx_tick_q;

	assign mem_write    = '{en: wr_en, addr: wr_addr, data: word};
	assign cpu_run      = (state == running);
	assign debug_active = (state == programming);

	// fetch unit is idle while sending, so status is stable here
	always_comb
	begin
		if (tx_idx == '0)
			report_byte = byte_t'(status.pc);	// zero extended
		else
			report_byte = {7'b0, status.halted};
	end

	//////////////////////////////////////////////////
	// control FSM

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= idle;
			rx_tick_q   <= 1'b0;
			tx_tick_q   <= 1'b0;
			byte_cnt    <= '0;
			wr_en       <= 1'b0;
			wr_addr     <= '0;
			fetch_clear <= 1'b0;
			cpu_step    <= 1'b0;
			tx_start    <= 1'b0;
			tx_busy     <= 1'b0;
			tx_idx      <= '0;
			from_step   <= 1'b0;
		end
		else
		begin
			rx_tick_q   <= rx_done_tick;
			tx_tick_q   <= tx_done_tick;
			fetch_clear <= 1'b0;	// pulses
			cpu_step    <= 1'b0;
			tx_start    <= 1'b0;
			wr_en       <= 1'b0;

			case (state)
				idle:
				begin
					if (rx_edge && rx_data == cmd_start)
					begin
						byte_cnt    <= '0;
						wr_addr     <= '0;
						fetch_clear <= 1'b1;
						state       <= programming;
					end
				end

				programming:
				begin
					if (wr_en)
					begin
						wr_addr <= wr_addr + 1'b1;	// wraps at 64
						if (is_halt(word))
							state <= waiting;
					end
					if (rx_edge)
					begin
						byte_cnt <= byte_cnt + 1'b1;
						wr_en    <= (byte_cnt == 2'd3);	// word complete
					end
				end

				waiting:
				begin
					if (rx_edge)
					begin
						case (rx_data)
							cmd_continuous: state <= running;
							cmd_step_mode:  state <= step_mode;
							cmd_reprogram:  state <= idle;
							default:        state <= idle;	// unknown command
						endcase
					end
				end

				running:
				begin
					if (status.halted)
					begin
						from_step <= 1'b0;
						state     <= sending;
					end
				end

				step_mode:
				begin
					// report goes out after the step has taken effect
					if (cpu_step)
					begin
						from_step <= 1'b1;
						state     <= sending;
					end
					else if (rx_edge && rx_data == cmd_step)
						cpu_step <= 1'b1;
				end

				sending:
				begin
					if (!tx_busy)
					begin
						tx_start <= 1'b1;
						tx_busy  <= 1'b1;
					end
					else if (tx_edge)
					begin
						tx_busy <= 1'b0;
						if (int'(tx_idx) == report_bytes - 1)
						begin
							tx_idx <= '0;
							state  <= from_step ? step_mode : waiting;
						end
						else
							tx_idx <= tx_idx + 1'b1;
					end
				end

				default: state <= idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// payload registers

	always_ff @(posedge clk)
	begin
		if (state == programming && rx_edge)
			word[byte_cnt*8 +: 8] <= rx_data;	// low byte first
		if (state == sending && !tx_busy)
			tx_data <= report_byte;	// held until next byte
	end

endmodule

//--- rtl/debug_top.sv
module debug_top
	import cpu_pkg::*, debug_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          rx_done_tick,
	input  byte_t         rx_data,
	input  logic          tx_done_tick,
	output logic          tx_start,
	output byte_t         tx_data,
	output logic          debug_active,
	output fetch_status_t status
);

	mem_write_t            mem_write;
	logic                  fetch_clear;
	logic                  cpu_run;
	logic                  cpu_step;
	logic [addr_width-1:0] rd_addr;
	inst_t                 rd_data;

	debug_unit u_debug_unit (
		.clk          (clk),
		.reset        (reset),
		.rx_done_tick (rx_done_tick),
		.rx_data      (rx_data),
		.tx_done_tick (tx_done_tick),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.status       (status),
		.mem_write    (mem_write),
		.fetch_clear  (fetch_clear),
		.cpu_run      (cpu_run),
		.cpu_step     (cpu_step),
		.debug_active (debug_active)
	);

	inst_mem u_inst_mem (
		.clk       (clk),
		.mem_write (mem_write),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.reset       (reset),
		.fetch_clear (fetch_clear),
		.cpu_run     (cpu_run),
		.cpu_step    (cpu_step),
		.rd_data     (rd_data),
		.rd_addr     (rd_addr),
		.status      (status)
	);

endmodule

//--- sim/debug_checker.sv
module debug_checker
	import cpu_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       tx_start,
	input logic       cpu_run,
	input logic       cpu_step,
	input mem_write_t mem_write,
	input logic       debug_active
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	//////////////////////////////////////////////////
	// control outputs of the debug unit

	tx_start_pulse: assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
	else
	begin
		fail_count++;
		$error("tx_start high two cycles in a row");
	end

	run_step_exclusive: assert property (@(posedge clk) disable iff (reset) !(cpu_run && cpu_step))
	else
	begin
		fail_count++;
		$error("cpu_run and cpu_step high together");
	end

	// write lands one clock after the fourth byte, still inside programming
	write_in_download: assert property (@(posedge clk) disable iff (reset)
		mem_write.en |-> $past(debug_active))
	else
	begin
		fail_count++;
		$error("mem_write enable outside program download");
	end

endmodule

bind debug_unit debug_checker u_checker (.*);

//--- sim/debug_top_tb.sv
module debug_top_tb
	import cpu_pkg::*, debug_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_sessions   = 8;
	localparam int session_cycles = 3000;	// 84 bytes plus up to 24 reports, worst case
	localparam int margin         = 2;

	logic          clk;
	logic          reset;
	logic          rx_done_tick;
	byte_t         rx_data;
	logic          tx_done_tick;
	logic          tx_start;
	byte_t         tx_data;
	logic          debug_active;
	fetch_status_t status;

	inst_t                 mem_model [mem_depth];
	logic [addr_width-1:0] model_pc;
	logic                  model_halted;
	byte_t                 report_q [$];	// bytes the host has received

	debug_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// reporting and reference model

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
		fail_run($sformatf("** Error: %s expected %h got %h", name, exp, got));
	endtask

	function automatic logic halt_word(input inst_t w);
		return w[31:26] == 6'b111111;
	endfunction

	// one fetch step, as the host sees it
	function automatic void model_advance();
		if (!model_halted)
		begin
			if (halt_word(mem_model[model_pc]))
				model_halted = 1'b1;
			else
				model_pc = model_pc + 1'b1;
		end
	endfunction

	//////////////////////////////////////////////////
	// host side

	task automatic send_byte(input byte_t b);
		rx_data      = b;
		rx_done_tick = 1'b1;
		@(negedge clk);
		rx_done_tick = 1'b0;
		repeat ($urandom_range(1, 6)) @(negedge clk);	// random gap
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_report();
		byte_t pc_byte;
		byte_t flag_byte;
		while (report_q.size() < report_bytes)
			@(negedge clk);
		pc_byte   = report_q.pop_front();
		flag_byte = report_q.pop_front();
		assert (pc_byte == byte_t'(model_pc))
		else value_error("tx_data byte 0", 32'(model_pc), 32'(pc_byte));
		assert (flag_byte == {7'b0, model_halted})
		else value_error("tx_data byte 1", 32'(model_halted), 32'(flag_byte));
		assert (status.pc == model_pc)
		else value_error("status.pc", 32'(model_pc), 32'(status.pc));
		assert (status.halted == model_halted)
		else value_error("status.halted", 32'(model_halted), 32'(status.halted));
		assert (status.instr == mem_model[model_pc])
		else value_error("status.instr", mem_model[model_pc], status.instr);
	endtask

	// n random words, then a halt word at index n
	task automatic load_program(output int n);
		inst_t w;
		n = $urandom_range(1, 20);
		send_byte(byte_t'($urandom_range(2, 255)));	// anything but start
		assert (!debug_active) else fail_run("debug_active rose on a non-start byte in idle");
		send_byte(cmd_start);
		model_pc     = '0;
		model_halted = 1'b0;
		for (int i = 0; i <= n; i++)
		begin
			assert (debug_active) else fail_run("debug_active low during program download");
			w = $urandom;
			if (i == n)
				w[31:26] = 6'b111111;
			else if (halt_word(w))
				w[31] = 1'b0;
			mem_model[6'(i)] = w;
			for (int k = 0; k < 4; k++)
				send_byte(w[k*8 +: 8]);	// low byte first
		end
		assert (!debug_active) else fail_run("debug_active still high after the halt word");
	endtask

	// tx side of the link, slow on purpose
	initial
	begin
		byte_t held;
		tx_done_tick = 1'b0;
		forever
		begin
			@(negedge clk);
			if (tx_start)
			begin
				held = tx_data;
				repeat ($urandom_range(1, 30))
				begin
					@(negedge clk);
					assert (!tx_start) else fail_run("second tx_start before tx_done_tick");
					assert (tx_data == held) else value_error("tx_data", 32'(held), 32'(tx_data));
				end
				tx_done_tick = 1'b1;
				@(negedge clk);
				tx_done_tick = 1'b0;
				report_q.push_back(held);
			end
		end
	end

	initial
	begin
		repeat (num_sessions * session_cycles * margin) @(posedge clk);
		fail_run("timeout: the host sessions did not finish in time");
	end

	//////////////////////////////////////////////////
	// sessions

	initial
	begin
		int n;
		logic prev_step;
		void'($urandom(74));
		reset        = 1'b1;
		rx_done_tick = 1'b0;
		rx_data      = '0;
		prev_step    = 1'b0;
		apply_reset();
		for (int s = 0; s < num_sessions; s++)
		begin
			if (prev_step)
				apply_reset();	// step_mode has no way out
			else if (s > 0)
				send_byte(cmd_reprogram);
			load_program(n);
			prev_step = 1'($urandom_range(0, 1));
			if (prev_step)
			begin
				send_byte(cmd_step_mode);
				repeat (n + 1 + $urandom_range(1, 3))	// a few past the halt word
				begin
					send_byte(cmd_step);
					model_advance();
					check_report();
				end
			end
			else
			begin
				send_byte(cmd_continuous);
				while (!model_halted)
					model_advance();
				check_report();
			end
		end
		repeat (4) @(negedge clk);
		if (uut.u_debug_unit.u_checker.fail_count != 0)
			fail_run("a concurrent assertion on the debug unit failed");
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

//--- project.f
rtl/cpu_pkg.sv
rtl/debug_pkg.sv
rtl/inst_mem.sv
rtl/fetch_unit.sv
rtl/debug_unit.sv
rtl/debug_top.sv
sim/debug_checker.sv
sim/debug_top_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --top-module debug_top_tb -f project.f -o Vdebug_top_tb
	-./obj_dir/Vdebug_top_tb > sim.log 2>&1
	cat sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
